// ==== source/link_protocol_pkg.sv ====
`default_nettype none

package link_protocol_pkg;

    // one byte on the host link
    typedef logic [7:0] byte_t;

    // escape prefix, followed by an instruction code or a second escape
    localparam byte_t ESCAPE_BYTE = 8'hFE;

    // ==================================================================
    // instruction codes sent after an escape
    // ==================================================================
    localparam byte_t CMD_IDLE           = 8'h00;
    localparam byte_t CMD_ACK            = 8'h01;
    localparam byte_t CMD_SET_NUM_IMAGES = 8'h02;
    localparam byte_t CMD_OFFSET_H       = 8'h03;
    localparam byte_t CMD_OFFSET_V       = 8'h04;
    localparam byte_t CMD_DISPLAY_CYC    = 8'h05;
    localparam byte_t CMD_START_SEQ      = 8'h06;
    localparam byte_t CMD_GALVO_X        = 8'h07;
    localparam byte_t CMD_GALVO_Y        = 8'h08;

    // any other code after an escape is an invalid instruction

endpackage

`default_nettype wire

// ==== source/ctrl_types_pkg.sv ====
`default_nettype none

package ctrl_types_pkg;

    // command FSM states
    typedef enum logic [4:0] {
        ST_IDLE,
        ST_ERROR,
        ST_WAIT_ACK,
        ST_OFFSET_MAG,
        ST_OFFSET_SIGN,
        ST_DISP_LO,
        ST_DISP_HI,
        ST_GALVO_B0,
        ST_GALVO_B1,
        ST_GALVO_B2,
        ST_NUM_IMAGES,
        ST_SEQ_TRIGGER
    } fsm_state_t;

    // target register of a byte-lane write
    typedef enum logic [2:0] {
        SEL_OFFSET_H,
        SEL_OFFSET_V,
        SEL_DISPLAY,
        SEL_GALVO_X,
        SEL_GALVO_Y,
        SEL_NUM_IMAGES
    } field_sel_t;

    typedef logic [1:0] lane_t;

    // ==================================================================
    // control register payloads
    // ==================================================================
    // lane 0 holds the magnitude, lane 1 the sign byte
    typedef logic [15:0] offset_word_t;
    typedef logic [7:0]  offset_mag_t;
    typedef logic [15:0] disp_cycles_t;
    typedef logic [23:0] galvo_t;
    typedef logic [6:0]  image_count_t;

    // magnitudes with the top bit set read as this value
    localparam offset_mag_t OFFSET_LIMIT = 8'd128;

endpackage

`default_nettype wire

// ==== source/byte_field_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_field_reg
    import link_protocol_pkg::*, ctrl_types_pkg::*;
#(
    parameter type FIELD_T = logic [7:0]
) (
    input  wire logic  iCLK,
    input  wire logic  iRST,
    input  wire logic  i_wr_en,
    input  wire lane_t i_wr_lane,
    input  wire byte_t i_wr_byte,
    output FIELD_T     o_value
);

    localparam int WIDTH = $bits(FIELD_T);

    logic [WIDTH-1:0] value_q;

    // bit-wise lane select, a short top lane keeps only its low bits
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            value_q <= '0;
        end else if (i_wr_en) begin
            for (int b = 0; b < WIDTH; b++) begin
                if ((b / 8) == int'(i_wr_lane)) begin
                    value_q[b] <= i_wr_byte[b % 8];
                end
            end
        end
    end

    assign o_value = FIELD_T'(value_q);

endmodule

`default_nettype wire

// ==== source/stream_unescape.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_unescape
    import link_protocol_pkg::*;
(
    input  wire logic  iCLK,
    input  wire logic  iRST,
    input  wire logic  i_rx_req,
    input  wire byte_t i_rx_byte,
    input  wire logic  i_item_consume,
    output logic       o_rx_ack,
    output logic       o_item_valid,
    output logic       o_item_is_instr,
    output byte_t      o_item_byte
);

    logic  ack_q;
    logic  take_q;
    logic  take_now;
    logic  esc_pend_q;
    logic  item_valid_q;
    logic  item_is_instr_q;
    byte_t rx_byte_q;
    byte_t item_byte_q;

    // ==================================================================
    // four-phase slave side
    // ==================================================================
    // no new byte is accepted while an item waits for the FSM
    assign take_now = i_rx_req && !ack_q && !item_valid_q;

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            ack_q  <= 1'b0;
            take_q <= 1'b0;
        end else begin
            take_q <= take_now;
            if (take_now) begin
                ack_q <= 1'b1;
            end else if (ack_q && !i_rx_req) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge iCLK) begin
        if (take_now) begin
            rx_byte_q <= i_rx_byte;
        end
    end

    // ==================================================================
    // escape removal and item holding
    // ==================================================================
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            esc_pend_q   <= 1'b0;
            item_valid_q <= 1'b0;
        end else if (take_q) begin
            if (esc_pend_q) begin
                // code or literal escape after the prefix
                esc_pend_q   <= 1'b0;
                item_valid_q <= 1'b1;
            end else if (rx_byte_q == ESCAPE_BYTE) begin
                esc_pend_q <= 1'b1;
            end else begin
                item_valid_q <= 1'b1;
            end
        end else if (i_item_consume) begin
            item_valid_q <= 1'b0;
        end
    end

    // escape followed by escape is plain data 0xFE
    always_ff @(posedge iCLK) begin
        if (take_q) begin
            item_byte_q     <= rx_byte_q;
            item_is_instr_q <= esc_pend_q && (rx_byte_q != ESCAPE_BYTE);
        end
    end

    assign o_rx_ack        = ack_q;
    assign o_item_valid    = item_valid_q;
    assign o_item_is_instr = item_is_instr_q;
    assign o_item_byte     = item_byte_q;

endmodule

`default_nettype wire

// ==== source/command_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_fsm
    import link_protocol_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic  iCLK,
    input  wire logic  iRST,
    input  wire logic  i_item_valid,
    input  wire logic  i_item_is_instr,
    input  wire byte_t i_item_byte,
    output logic       o_item_consume,
    output logic       o_wr_en,
    output field_sel_t o_wr_sel,
    output lane_t      o_wr_lane,
    output byte_t      o_wr_byte,
    output logic       o_seq_trigger,
    output logic       o_error
);

    fsm_state_t state_q;
    fsm_state_t state_d;
    // low selects horizontal or X, high selects vertical or Y
    logic       axis_q;
    logic       axis_d;
    fsm_state_t seq_next;

    // ==================================================================
    // per-state lane, target and successor of a data byte
    // ==================================================================
    always_comb begin
        o_wr_sel  = SEL_OFFSET_H;
        o_wr_lane = 2'd0;
        seq_next  = ST_WAIT_ACK;
        case (state_q)
            ST_OFFSET_MAG: begin
                o_wr_sel = axis_q ? SEL_OFFSET_V : SEL_OFFSET_H;
                seq_next = ST_OFFSET_SIGN;
            end
            ST_OFFSET_SIGN: begin
                o_wr_sel  = axis_q ? SEL_OFFSET_V : SEL_OFFSET_H;
                o_wr_lane = 2'd1;
            end
            ST_DISP_LO: begin
                o_wr_sel = SEL_DISPLAY;
                seq_next = ST_DISP_HI;
            end
            ST_DISP_HI: begin
                o_wr_sel  = SEL_DISPLAY;
                o_wr_lane = 2'd1;
            end
            ST_GALVO_B0: begin
                o_wr_sel = axis_q ? SEL_GALVO_Y : SEL_GALVO_X;
                seq_next = ST_GALVO_B1;
            end
            ST_GALVO_B1: begin
                o_wr_sel  = axis_q ? SEL_GALVO_Y : SEL_GALVO_X;
                o_wr_lane = 2'd1;
                seq_next  = ST_GALVO_B2;
            end
            ST_GALVO_B2: begin
                o_wr_sel  = axis_q ? SEL_GALVO_Y : SEL_GALVO_X;
                o_wr_lane = 2'd2;
            end
            ST_NUM_IMAGES: begin
                o_wr_sel = SEL_NUM_IMAGES;
            end
            default: begin
                seq_next = ST_WAIT_ACK;
            end
        endcase
    end

    // ==================================================================
    // transitions
    // ==================================================================
    always_comb begin
        state_d        = state_q;
        axis_d         = axis_q;
        o_item_consume = 1'b0;
        o_wr_en        = 1'b0;
        case (state_q)
            ST_IDLE, ST_ERROR: begin
                // only instructions matter here, data is dropped
                o_item_consume = i_item_valid;
                if (i_item_valid && i_item_is_instr) begin
                    case (i_item_byte)
                        CMD_IDLE, CMD_ACK: state_d = ST_IDLE;
                        CMD_OFFSET_H: begin
                            state_d = ST_OFFSET_MAG;
                            axis_d  = 1'b0;
                        end
                        CMD_OFFSET_V: begin
                            state_d = ST_OFFSET_MAG;
                            axis_d  = 1'b1;
                        end
                        CMD_GALVO_X: begin
                            state_d = ST_GALVO_B0;
                            axis_d  = 1'b0;
                        end
                        CMD_GALVO_Y: begin
                            state_d = ST_GALVO_B0;
                            axis_d  = 1'b1;
                        end
                        CMD_DISPLAY_CYC:    state_d = ST_DISP_LO;
                        CMD_SET_NUM_IMAGES: state_d = ST_NUM_IMAGES;
                        CMD_START_SEQ:      state_d = ST_SEQ_TRIGGER;
                        default:            state_d = ST_ERROR;
                    endcase
                end
            end
            ST_WAIT_ACK: begin
                o_item_consume = i_item_valid;
                if (i_item_valid) begin
                    if (i_item_is_instr && i_item_byte == CMD_ACK) begin
                        state_d = ST_IDLE;
                    end else begin
                        state_d = ST_ERROR;
                    end
                end
            end
            ST_SEQ_TRIGGER: begin
                state_d = ST_WAIT_ACK;
            end
            default: begin
                // inside a byte sequence, an instruction aborts it
                o_item_consume = i_item_valid;
                if (i_item_valid && i_item_is_instr) begin
                    state_d = (i_item_byte == CMD_IDLE) ? ST_IDLE : ST_ERROR;
                end else if (i_item_valid) begin
                    o_wr_en = 1'b1;
                    state_d = seq_next;
                end
            end
        endcase
    end

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            state_q <= ST_IDLE;
            axis_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            axis_q  <= axis_d;
        end
    end

    assign o_wr_byte     = i_item_byte;
    assign o_seq_trigger = (state_q == ST_SEQ_TRIGGER);
    assign o_error       = (state_q == ST_ERROR);

endmodule

`default_nettype wire

// ==== source/control_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_regs
    import link_protocol_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic       iCLK,
    input  wire logic       iRST,
    input  wire logic       i_wr_en,
    input  wire field_sel_t i_wr_sel,
    input  wire lane_t      i_wr_lane,
    input  wire byte_t      i_wr_byte,
    output offset_mag_t     o_h_offset,
    output logic            o_h_offset_sign,
    output offset_mag_t     o_v_offset,
    output logic            o_v_offset_sign,
    output disp_cycles_t    o_display_cycles,
    output galvo_t          o_galvo_x,
    output galvo_t          o_galvo_y,
    output image_count_t    o_num_images
);

    logic [5:0]   field_we;
    offset_word_t h_word;
    offset_word_t v_word;

    // one enable per field, in field_sel_t order
    always_comb begin
        field_we = '0;
        field_we[i_wr_sel] = i_wr_en;
    end

    byte_field_reg #(.FIELD_T(offset_word_t)) h_offset_reg (
        .iCLK(iCLK), .iRST(iRST), .i_wr_en(field_we[SEL_OFFSET_H]),
        .i_wr_lane(i_wr_lane), .i_wr_byte(i_wr_byte), .o_value(h_word)
    );
    byte_field_reg #(.FIELD_T(offset_word_t)) v_offset_reg (
        .iCLK(iCLK), .iRST(iRST), .i_wr_en(field_we[SEL_OFFSET_V]),
        .i_wr_lane(i_wr_lane), .i_wr_byte(i_wr_byte), .o_value(v_word)
    );
    byte_field_reg #(.FIELD_T(disp_cycles_t)) display_reg (
        .iCLK(iCLK), .iRST(iRST), .i_wr_en(field_we[SEL_DISPLAY]),
        .i_wr_lane(i_wr_lane), .i_wr_byte(i_wr_byte), .o_value(o_display_cycles)
    );
    byte_field_reg #(.FIELD_T(galvo_t)) galvo_x_reg (
        .iCLK(iCLK), .iRST(iRST), .i_wr_en(field_we[SEL_GALVO_X]),
        .i_wr_lane(i_wr_lane), .i_wr_byte(i_wr_byte), .o_value(o_galvo_x)
    );
    byte_field_reg #(.FIELD_T(galvo_t)) galvo_y_reg (
        .iCLK(iCLK), .iRST(iRST), .i_wr_en(field_we[SEL_GALVO_Y]),
        .i_wr_lane(i_wr_lane), .i_wr_byte(i_wr_byte), .o_value(o_galvo_y)
    );
    byte_field_reg #(.FIELD_T(image_count_t)) num_images_reg (
        .iCLK(iCLK), .iRST(iRST), .i_wr_en(field_we[SEL_NUM_IMAGES]),
        .i_wr_lane(i_wr_lane), .i_wr_byte(i_wr_byte), .o_value(o_num_images)
    );

    // ==================================================================
    // offset clamp and sign
    // ==================================================================
    assign o_h_offset      = h_word[7] ? OFFSET_LIMIT : h_word[7:0];
    assign o_v_offset      = v_word[7] ? OFFSET_LIMIT : v_word[7:0];
    // sign byte sits in lane 1, its bit 0 is word bit 8
    assign o_h_offset_sign = h_word[8];
    assign o_v_offset_sign = v_word[8];

endmodule

`default_nettype wire

// ==== source/jtag_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_top
    import link_protocol_pkg::*, ctrl_types_pkg::*;
(
    input  wire logic    iCLK,
    input  wire logic    iRST,
    input  wire logic    i_rx_req,
    input  wire byte_t   i_rx_byte,
    output logic         o_rx_ack,
    output logic         o_seq_trigger,
    output logic         o_error,
    output offset_mag_t  o_h_offset,
    output logic         o_h_offset_sign,
    output offset_mag_t  o_v_offset,
    output logic         o_v_offset_sign,
    output disp_cycles_t o_display_cycles,
    output galvo_t       o_galvo_x,
    output galvo_t       o_galvo_y,
    output image_count_t o_num_images
);

    // receiver to FSM
    logic       item_valid;
    logic       item_is_instr;
    byte_t      item_byte;
    logic       item_consume;

    // FSM to registers
    logic       wr_en;
    field_sel_t wr_sel;
    lane_t      wr_lane;
    byte_t      wr_byte;

    stream_unescape rx_i (
        .iCLK            (iCLK),
        .iRST            (iRST),
        .i_rx_req        (i_rx_req),
        .i_rx_byte       (i_rx_byte),
        .i_item_consume  (item_consume),
        .o_rx_ack        (o_rx_ack),
        .o_item_valid    (item_valid),
        .o_item_is_instr (item_is_instr),
        .o_item_byte     (item_byte)
    );

    command_fsm fsm_i (
        .iCLK            (iCLK),
        .iRST            (iRST),
        .i_item_valid    (item_valid),
        .i_item_is_instr (item_is_instr),
        .i_item_byte     (item_byte),
        .o_item_consume  (item_consume),
        .o_wr_en         (wr_en),
        .o_wr_sel        (wr_sel),
        .o_wr_lane       (wr_lane),
        .o_wr_byte       (wr_byte),
        .o_seq_trigger   (o_seq_trigger),
        .o_error         (o_error)
    );

    control_regs regs_i (
        .iCLK             (iCLK),
        .iRST             (iRST),
        .i_wr_en          (wr_en),
        .i_wr_sel         (wr_sel),
        .i_wr_lane        (wr_lane),
        .i_wr_byte        (wr_byte),
        .o_h_offset       (o_h_offset),
        .o_h_offset_sign  (o_h_offset_sign),
        .o_v_offset       (o_v_offset),
        .o_v_offset_sign  (o_v_offset_sign),
        .o_display_cycles (o_display_cycles),
        .o_galvo_x        (o_galvo_x),
        .o_galvo_y        (o_galvo_y),
        .o_num_images     (o_num_images)
    );

endmodule

`default_nettype wire

// ==== test/jtag_ctrl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_properties
    import ctrl_types_pkg::*;
(
    input  wire logic       iCLK,
    input  wire logic       iRST,
    input  wire logic       i_rx_req,
    input  wire logic       i_rx_ack,
    input  wire logic       i_seq_trigger,
    input  wire logic       i_wr_en,
    input  wire fsm_state_t i_state
);

    int fail_count = 0;

    // the slave only answers a pending request
    ack_needs_req: assert property (@(posedge iCLK) disable iff (iRST)
        $rose(i_rx_ack) |-> $past(i_rx_req))
    else begin
        fail_count++;
        $error("ack rose while req was low");
    end

    trigger_one_cycle: assert property (@(posedge iCLK) disable iff (iRST)
        i_seq_trigger |=> !i_seq_trigger)
    else begin
        fail_count++;
        $error("sequence trigger lasted more than one cycle");
    end

    // idle and error never write a register
    no_write_when_idle: assert property (@(posedge iCLK) disable iff (iRST)
        (i_state == ST_IDLE || i_state == ST_ERROR) |-> !i_wr_en)
    else begin
        fail_count++;
        $error("register write in idle or error state");
    end

endmodule

// receiver instance, FSM side held quiet
bind stream_unescape jtag_ctrl_properties props_i (
    .iCLK(iCLK), .iRST(iRST), .i_rx_req(i_rx_req), .i_rx_ack(o_rx_ack),
    .i_seq_trigger(1'b0), .i_wr_en(1'b0), .i_state(ctrl_types_pkg::ST_IDLE)
);

// FSM instance, handshake side held quiet
bind command_fsm jtag_ctrl_properties props_i (
    .iCLK(iCLK), .iRST(iRST), .i_rx_req(1'b0), .i_rx_ack(1'b0),
    .i_seq_trigger(o_seq_trigger), .i_wr_en(o_wr_en), .i_state(state_q)
);

`default_nettype wire

// ==== test/jtag_ctrl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_checker
    import ctrl_types_pkg::*;
(
    input  wire logic         iCLK,
    input  wire logic         iRST,
    // watched DUT outputs
    input  wire logic         i_seq_trigger,
    input  wire logic         i_error,
    input  wire offset_mag_t  i_h_offset,
    input  wire logic         i_h_offset_sign,
    input  wire offset_mag_t  i_v_offset,
    input  wire logic         i_v_offset_sign,
    input  wire disp_cycles_t i_display_cycles,
    input  wire galvo_t       i_galvo_x,
    input  wire galvo_t       i_galvo_y,
    input  wire image_count_t i_num_images,
    // compare strobe and expected values of the finished test
    input  wire logic         i_check,
    input  wire logic [7:0]   i_test_num,
    input  wire offset_mag_t  i_exp_h_offset,
    input  wire logic         i_exp_h_sign,
    input  wire offset_mag_t  i_exp_v_offset,
    input  wire logic         i_exp_v_sign,
    input  wire disp_cycles_t i_exp_display,
    input  wire galvo_t       i_exp_galvo_x,
    input  wire galvo_t       i_exp_galvo_y,
    input  wire image_count_t i_exp_num_images,
    input  wire logic         i_exp_error,
    input  wire logic [3:0]   i_exp_triggers,
    output int                o_tests_run,
    output int                o_tests_failed,
    output int                o_mismatches
);

    int         test_errors;
    logic [3:0] trigger_count;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: test %0d %s is %0h, expected %0h",
                     $time, i_test_num, name, got, want);
            test_errors++;
        end
    endtask

    always @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            trigger_count  = '0;
            test_errors    = 0;
            o_tests_run    = 0;
            o_tests_failed = 0;
            o_mismatches   = 0;
        end else begin
            // trigger pulses since the previous compare
            if (i_seq_trigger) begin
                trigger_count = trigger_count + 4'd1;
            end
            if (i_check) begin
                test_errors = 0;
                compare_field("h_offset", 32'(i_h_offset), 32'(i_exp_h_offset));
                compare_field("h_sign", 32'(i_h_offset_sign), 32'(i_exp_h_sign));
                compare_field("v_offset", 32'(i_v_offset), 32'(i_exp_v_offset));
                compare_field("v_sign", 32'(i_v_offset_sign), 32'(i_exp_v_sign));
                compare_field("display", 32'(i_display_cycles), 32'(i_exp_display));
                compare_field("galvo_x", 32'(i_galvo_x), 32'(i_exp_galvo_x));
                compare_field("galvo_y", 32'(i_galvo_y), 32'(i_exp_galvo_y));
                compare_field("images", 32'(i_num_images), 32'(i_exp_num_images));
                compare_field("error", 32'(i_error), 32'(i_exp_error));
                compare_field("triggers", 32'(trigger_count), 32'(i_exp_triggers));
                o_tests_run  = o_tests_run + 1;
                o_mismatches = o_mismatches + test_errors;
                if (test_errors == 0) begin
                    $display("test %0d passed", i_test_num);
                end else begin
                    o_tests_failed = o_tests_failed + 1;
                    $display("test %0d failed with %0d mismatches", i_test_num, test_errors);
                end
                trigger_count = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/jtag_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_ctrl_tb
    import link_protocol_pkg::*, ctrl_types_pkg::*;
();

    localparam int NUM_TESTS  = 12;
    localparam int HS_TIMEOUT = 200;

    // byte list is right aligned, the last byte sent sits in the low bits
    typedef struct packed {
        logic [127:0] seq;
        logic [4:0]   len;
        offset_mag_t  h_off;
        logic         h_sign;
        offset_mag_t  v_off;
        logic         v_sign;
        disp_cycles_t disp;
        galvo_t       gx;
        galvo_t       gy;
        image_count_t n_img;
        logic         err;
        logic [3:0]   trig;
    } test_t;

    // ==================================================================
    // stimulus table, expected fields accumulate from row to row
    // ==================================================================
    // h_off h_sign v_off v_sign disp galvo_x galvo_y images error triggers
    test_t tests [NUM_TESTS] = '{
        '{128'h0, 5'd0,
          8'h00, 1'b0, 8'h00, 1'b0, 16'h0000, 24'h000000, 24'h000000, 7'h00, 1'b0, 4'd0},
        '{128'hFE_07_11_FE_FE_33_FE_01, 5'd8,
          8'h00, 1'b0, 8'h00, 1'b0, 16'h0000, 24'h33FE11, 24'h000000, 7'h00, 1'b0, 4'd0},
        '{128'hFE_08_FE_FE_5A_C3_FE_01, 5'd8,
          8'h00, 1'b0, 8'h00, 1'b0, 16'h0000, 24'h33FE11, 24'hC35AFE, 7'h00, 1'b0, 4'd0},
        '{128'hFE_03_85_01_FE_01_FE_04_7F_02_FE_01, 5'd12,
          8'h80, 1'b1, 8'h7F, 1'b0, 16'h0000, 24'h33FE11, 24'hC35AFE, 7'h00, 1'b0, 4'd0},
        // two data bytes while idle come first
        '{128'h55_AA_FE_05_34_12_FE_01_FE_02_FF_FE_01, 5'd13,
          8'h80, 1'b1, 8'h7F, 1'b0, 16'h1234, 24'h33FE11, 24'hC35AFE, 7'h7F, 1'b0, 4'd0},
        '{128'hFE_06_FE_01, 5'd4,
          8'h80, 1'b1, 8'h7F, 1'b0, 16'h1234, 24'h33FE11, 24'hC35AFE, 7'h7F, 1'b0, 4'd1},
        // invalid code, then data that the error state drops
        '{128'hFE_09_44, 5'd3,
          8'h80, 1'b1, 8'h7F, 1'b0, 16'h1234, 24'h33FE11, 24'hC35AFE, 7'h7F, 1'b1, 4'd0},
        '{128'hFE_04_80_01_FE_01, 5'd6,
          8'h80, 1'b1, 8'h80, 1'b1, 16'h1234, 24'h33FE11, 24'hC35AFE, 7'h7F, 1'b0, 4'd0},
        // start instead of ack after the last display byte
        '{128'hFE_05_10_20_FE_06, 5'd6,
          8'h80, 1'b1, 8'h80, 1'b1, 16'h2010, 24'h33FE11, 24'hC35AFE, 7'h7F, 1'b1, 4'd0},
        '{128'hFE_07_AB_FE_03, 5'd5,
          8'h80, 1'b1, 8'h80, 1'b1, 16'h2010, 24'h33FEAB, 24'hC35AFE, 7'h7F, 1'b1, 4'd0},
        // idle abort keeps the first galvo byte
        '{128'hFE_08_77_FE_00, 5'd5,
          8'h80, 1'b1, 8'h80, 1'b1, 16'h2010, 24'h33FEAB, 24'hC35A77, 7'h7F, 1'b0, 4'd0},
        '{128'hFE_06_FE_01_FE_06_FE_01, 5'd8,
          8'h80, 1'b1, 8'h80, 1'b1, 16'h2010, 24'h33FEAB, 24'hC35A77, 7'h7F, 1'b0, 4'd2}
    };

    logic         clk = 1'b0;
    logic         rst;
    logic         rx_req;
    byte_t        rx_byte;
    logic         rx_ack;
    logic         seq_trigger;
    logic         error;
    offset_mag_t  h_offset;
    logic         h_offset_sign;
    offset_mag_t  v_offset;
    logic         v_offset_sign;
    disp_cycles_t display_cycles;
    galvo_t       galvo_x;
    galvo_t       galvo_y;
    image_count_t num_images;

    logic         check;
    logic [7:0]   test_idx;
    test_t        cur;
    logic         timed_out;
    int           tests_run;
    int           tests_failed;
    int           mismatches;
    int           assert_fails;

    always #2 clk = ~clk;

    jtag_ctrl_top dut_i (
        .iCLK             (clk),
        .iRST             (rst),
        .i_rx_req         (rx_req),
        .i_rx_byte        (rx_byte),
        .o_rx_ack         (rx_ack),
        .o_seq_trigger    (seq_trigger),
        .o_error          (error),
        .o_h_offset       (h_offset),
        .o_h_offset_sign  (h_offset_sign),
        .o_v_offset       (v_offset),
        .o_v_offset_sign  (v_offset_sign),
        .o_display_cycles (display_cycles),
        .o_galvo_x        (galvo_x),
        .o_galvo_y        (galvo_y),
        .o_num_images     (num_images)
    );

    jtag_ctrl_checker checker_i (
        .iCLK               (clk),
        .iRST               (rst),
        .i_seq_trigger      (seq_trigger),
        .i_error            (error),
        .i_h_offset         (h_offset),
        .i_h_offset_sign    (h_offset_sign),
        .i_v_offset         (v_offset),
        .i_v_offset_sign    (v_offset_sign),
        .i_display_cycles   (display_cycles),
        .i_galvo_x          (galvo_x),
        .i_galvo_y          (galvo_y),
        .i_num_images       (num_images),
        .i_check            (check),
        .i_test_num         (test_idx),
        .i_exp_h_offset     (cur.h_off),
        .i_exp_h_sign       (cur.h_sign),
        .i_exp_v_offset     (cur.v_off),
        .i_exp_v_sign       (cur.v_sign),
        .i_exp_display      (cur.disp),
        .i_exp_galvo_x      (cur.gx),
        .i_exp_galvo_y      (cur.gy),
        .i_exp_num_images   (cur.n_img),
        .i_exp_error        (cur.err),
        .i_exp_triggers     (cur.trig),
        .o_tests_run        (tests_run),
        .o_tests_failed     (tests_failed),
        .o_mismatches       (mismatches)
    );

    // failures seen by the bound assertions in the receiver and the FSM
    assign assert_fails = dut_i.rx_i.props_i.fail_count + dut_i.fsm_i.props_i.fail_count;

    // four-phase handshake for one byte, after a random idle gap
    task automatic send_byte(input byte_t b);
        int cnt;
        cnt = 0;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        rx_byte <= b;
        rx_req  <= 1'b1;
        while (!rx_ack && cnt < HS_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= HS_TIMEOUT) begin
            $display("timeout: DUT never raised ack for byte %h at %0t", b, $time);
            timed_out = 1'b1;
            return;
        end
        rx_req <= 1'b0;
        cnt = 0;
        while (rx_ack && cnt < HS_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= HS_TIMEOUT) begin
            $display("timeout: DUT kept ack high after byte %h at %0t", b, $time);
            timed_out = 1'b1;
        end
    endtask

    // the last decoded item must reach the FSM before the fields are checked
    task automatic wait_item_drain();
        int cnt;
        cnt = 0;
        while (dut_i.item_valid && cnt < HS_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= HS_TIMEOUT) begin
            $display("timeout: decoded item was never consumed at %0t", $time);
            timed_out = 1'b1;
        end
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial begin
        void'($urandom(32'h59b67674));
        rst       = 1'b1;
        rx_req    = 1'b0;
        rx_byte   = 8'h00;
        check     = 1'b0;
        test_idx  = 8'd0;
        cur       = '0;
        timed_out = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < int'(tests[t].len) && !timed_out; i++) begin
                send_byte(tests[t].seq[8*(int'(tests[t].len)-1-i) +: 8]);
            end
            if (!timed_out) begin
                wait_item_drain();
            end
            if (timed_out) begin
                break;
            end
            cur      <= tests[t];
            test_idx <= 8'(t);
            check    <= 1'b1;
            @(posedge clk);
            check <= 1'b0;
            @(posedge clk);
        end

        @(posedge clk);
        $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, mismatches, assert_fails);
        if (timed_out || tests_failed != 0 || tests_run != NUM_TESTS || assert_fails != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/link_protocol_pkg.sv
source/ctrl_types_pkg.sv
source/byte_field_reg.sv
source/stream_unescape.sv
source/command_fsm.sv
source/control_regs.sv
source/jtag_ctrl_top.sv
test/jtag_ctrl_properties.sv
test/jtag_ctrl_checker.sv
test/jtag_ctrl_tb.sv

// ==== Makefile ====
TOP := jtag_ctrl_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard source/*.sv test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
